// ==== Bender.yml ====
package:
  name: rxeq_scan

sources:
  - src/rxeq_types_pkg.sv
  - src/rxeq_ctrl_pkg.sv
  - src/rxeq_input_sync.sv
  - src/rxeq_scan_ctrl.sv
  - src/rxeq_coeff_eval.sv
  - src/rxeq_iter_counter.sv
  - src/rxeq_scan_top.sv
  - target: simulation
    files:
      - sim/rxeq_scan_asserts.sv
      - sim/rxeq_scan_tb.sv

// ==== rxeq_scan_top.f ====
src/rxeq_types_pkg.sv
src/rxeq_ctrl_pkg.sv
src/rxeq_input_sync.sv
src/rxeq_scan_ctrl.sv
src/rxeq_coeff_eval.sv
src/rxeq_iter_counter.sv
src/rxeq_scan_top.sv
sim/rxeq_scan_asserts.sv
sim/rxeq_scan_tb.sv

// ==== sim/rxeq_scan_asserts.sv ====
`timescale 1ns/1ps

module rxeq_scan_asserts
    import rxeq_types_pkg::*;
(
    input logic     rxeq_scan_clk,
    input logic     rxeq_scan_rst_n,
    input logic     preset_done,
    input logic     new_txcoeff_done,
    input txcoeff_t new_txcoeff
);

    // the reset is synchronous, so the done levels are clear one edge after it is sampled
    assert property (@(posedge rxeq_scan_clk)
        !rxeq_scan_rst_n |=> (!preset_done && !new_txcoeff_done))
        else $error("done level high while in reset");

    assert property (@(posedge rxeq_scan_clk) disable iff (!rxeq_scan_rst_n)
        !(preset_done && new_txcoeff_done))
        else $error("preset_done and new_txcoeff_done high together");

    assert property (@(posedge rxeq_scan_clk) disable iff (!rxeq_scan_rst_n)
        new_txcoeff_done |=> (!new_txcoeff_done || $stable(new_txcoeff)))
        else $error("new_txcoeff changed while new_txcoeff_done was high");

endmodule

bind rxeq_scan_top rxeq_scan_asserts i_asserts (
    .rxeq_scan_clk    (rxeq_scan_clk),
    .rxeq_scan_rst_n  (rxeq_scan_rst_n),
    .preset_done      (preset_done),
    .new_txcoeff_done (new_txcoeff_done),
    .new_txcoeff      (new_txcoeff)
);

// ==== sim/rxeq_scan_patterns.txt ====
# op txcoeff fs lf then expected new_txcoeff legal lffs_sel adapt_done, all in hex
# op P is a preset, C a coefficient request, B both raised together
P 00000 00 00 00000 0 0 0
C 04482 18 08 04482 1 0 0
C 063c3 18 08 04482 0 1 1
C 04500 18 08 04500 1 0 0
C 01501 18 08 04500 0 0 0
C 04404 18 08 04404 1 0 0
C 02094 18 08 04404 0 0 0
C 00600 18 08 00600 1 0 0
C 05385 18 08 00600 0 0 0
C 0ac05 3f 0f 0ac05 1 0 0
C 04482 18 08 04482 1 1 1
P 00000 00 00 04482 1 0 0
B 04500 18 08 04500 1 0 0
C 063c3 18 08 04500 0 0 0

// ==== sim/rxeq_scan_tb.sv ====
`timescale 1ns/1ps

module rxeq_scan_tb;
    import rxeq_types_pkg::*;

    localparam int TIMEOUT_CYCLES = 20;
    localparam int DONE_EDGES     = 3; // two synchronizer stages plus the done register

    logic     rxeq_scan_clk = 1'b0;
    logic     rxeq_scan_rst_n;
    logic     preset_valid;
    logic     new_txcoeff_req;
    txcoeff_t txcoeff;
    fslf_t    fs;
    fslf_t    lf;
    logic     preset_done;
    txcoeff_t new_txcoeff;
    logic     new_txcoeff_done;
    logic     new_txcoeff_legal;
    logic     lffs_sel;
    logic     adapt_done;

    int error_count = 0;
    bit timed_out   = 1'b0;

    always #4 rxeq_scan_clk = ~rxeq_scan_clk;

    rxeq_scan_top i_dut (
        .rxeq_scan_clk     (rxeq_scan_clk),
        .rxeq_scan_rst_n   (rxeq_scan_rst_n),
        .preset_valid      (preset_valid),
        .new_txcoeff_req   (new_txcoeff_req),
        .txcoeff           (txcoeff),
        .fs                (fs),
        .lf                (lf),
        .preset_done       (preset_done),
        .new_txcoeff       (new_txcoeff),
        .new_txcoeff_done  (new_txcoeff_done),
        .new_txcoeff_legal (new_txcoeff_legal),
        .lffs_sel          (lffs_sel),
        .adapt_done        (adapt_done)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0d ns: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_outputs(input txcoeff_t exp_coeff, input logic exp_legal,
                                   input logic exp_lffs, input logic exp_adapt);
        check_value("new_txcoeff", exp_coeff, new_txcoeff);
        check_value("new_txcoeff_legal", exp_legal, new_txcoeff_legal);
        check_value("lffs_sel", exp_lffs, lffs_sel);
        check_value("adapt_done", exp_adapt, adapt_done);
    endtask

    // outputs are sampled on the falling edge, half a cycle clear of the DUT registers
    task automatic wait_done(input bit coeff_side, input logic level, output int edges);
        logic  cur;
        string name;
        name  = coeff_side ? "new_txcoeff_done" : "preset_done";
        edges = 0;
        cur   = ~level;
        while (cur !== level && edges < TIMEOUT_CYCLES && !timed_out)
        begin
            @(posedge rxeq_scan_clk);
            edges++;
            @(negedge rxeq_scan_clk);
            cur = coeff_side ? new_txcoeff_done : preset_done;
            check_value(coeff_side ? "preset_done" : "new_txcoeff_done", 0,
                        coeff_side ? preset_done : new_txcoeff_done); // one request at a time
        end
        if (!timed_out && cur !== level)
        begin
            $display("timeout at %0d ns: %s did not go to %0d within %0d cycles",
                     $time, name, level, TIMEOUT_CYCLES);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_pattern(input logic [7:0] op, input txcoeff_t coeff_in,
                               input fslf_t fs_in, input fslf_t lf_in,
                               input txcoeff_t exp_coeff, input logic exp_legal,
                               input logic exp_lffs, input logic exp_adapt);
        int edges;
        @(posedge rxeq_scan_clk);
        txcoeff         <= coeff_in;
        fs              <= fs_in;
        lf              <= lf_in;
        preset_valid    <= (op != "C");
        new_txcoeff_req <= (op != "P"); // B raises both in the same cycle
        if (op != "C")
        begin
            wait_done(1'b0, 1'b1, edges);
            if (!timed_out)
            begin
                check_value("preset_done rise edges", DONE_EDGES, edges);
            end
            if (!timed_out && op == "P")
            begin
                compare_outputs(exp_coeff, exp_legal, exp_lffs, exp_adapt);
            end
            @(posedge rxeq_scan_clk);
            preset_valid <= 1'b0;
            wait_done(1'b0, 1'b0, edges);
        end
        if (op != "P")
        begin
            wait_done(1'b1, 1'b1, edges);
            if (!timed_out && op == "C")
            begin
                check_value("new_txcoeff_done rise edges", DONE_EDGES, edges);
            end
            if (!timed_out)
            begin
                compare_outputs(exp_coeff, exp_legal, exp_lffs, exp_adapt);
            end
            @(posedge rxeq_scan_clk);
            new_txcoeff_req <= 1'b0;
            wait_done(1'b1, 1'b0, edges);
        end
    endtask

    initial
    begin
        int         fd;
        int         code;
        int         fields;
        int         pattern_index;
        int         errors_before;
        string      line;
        logic [7:0] op;
        txcoeff_t   coeff_in;
        fslf_t      fs_in;
        fslf_t      lf_in;
        txcoeff_t   exp_coeff;
        logic       exp_legal;
        logic       exp_lffs;
        logic       exp_adapt;
        rxeq_scan_rst_n = 1'b0;
        preset_valid    = 1'b0;
        new_txcoeff_req = 1'b0;
        txcoeff         = '0;
        fs              = '0;
        lf              = '0;
        pattern_index   = 0;
        repeat (2) @(posedge rxeq_scan_clk);
        rxeq_scan_rst_n <= 1'b1;
        @(negedge rxeq_scan_clk);
        compare_outputs('0, 1'b0, 1'b0, 1'b0);
        check_value("preset_done", 0, preset_done);
        check_value("new_txcoeff_done", 0, new_txcoeff_done);
        $display("reset values: %s", (error_count == 0) ? "ok" : "errors");
        fd = $fopen("sim/rxeq_scan_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the pattern file sim/rxeq_scan_patterns.txt");
            error_count++;
        end
        else
        begin
            while (!$feof(fd) && !timed_out)
            begin
                code   = $fgets(line, fd);
                fields = $sscanf(line, "%c %h %h %h %h %h %h %h", op, coeff_in, fs_in, lf_in,
                                 exp_coeff, exp_legal, exp_lffs, exp_adapt);
                if (code > 0 && line[0] != "#" && fields == 8)
                begin
                    pattern_index++;
                    errors_before = error_count;
                    run_pattern(op, coeff_in, fs_in, lf_in, exp_coeff, exp_legal,
                                exp_lffs, exp_adapt);
                    $display("pattern %0d (%c): %s", pattern_index, op,
                             (error_count == errors_before && !timed_out) ? "ok" : "errors");
                end
            end
            $fclose(fd);
        end
        if (pattern_index == 0)
        begin
            $display("no pattern was read from the pattern file");
            error_count++;
        end
        $display("%0d patterns run, %0d errors, timeout %0d", pattern_index, error_count,
                 timed_out);
        if (error_count == 0 && !timed_out)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== src/rxeq_coeff_eval.sv ====
`timescale 1ns/1ps

module rxeq_coeff_eval
    import rxeq_types_pkg::*;
(
    input  logic     rxeq_scan_clk,
    input  logic     rxeq_scan_rst_n,
    input  logic     coeff_accept,
    input  txcoeff_t txcoeff_sync,
    input  fslf_t    fs_sync,
    input  fslf_t    lf_sync,
    output txcoeff_t new_txcoeff,
    output logic     new_txcoeff_legal
);

    coeff_field_t pre;
    coeff_field_t main_c;
    coeff_field_t post;
    logic [7:0]   cursor_sum;
    logic [7:0]   main_floor;
    logic         triple_legal;

    assign pre    = txcoeff_sync[PRE_LSB  +: 6];
    assign main_c = txcoeff_sync[MAIN_LSB +: 6];
    assign post   = txcoeff_sync[POST_LSB +: 6];

    // eight bits hold the worst case sum of three six bit fields
    assign cursor_sum = {2'b00, pre} + {2'b00, main_c} + {2'b00, post};

    // main - pre - post >= lf is rewritten as main >= pre + post + lf so
    // nothing can wrap below zero
    assign main_floor = {2'b00, pre} + {2'b00, post} + {2'b00, lf_sync};

    assign triple_legal = (cursor_sum == {2'b00, fs_sync}) && ({2'b00, main_c} >= main_floor);

    always_ff @(posedge rxeq_scan_clk)
    begin
        if (!rxeq_scan_rst_n)
        begin
            new_txcoeff       <= '0;
            new_txcoeff_legal <= 1'b0;
        end
        else if (coeff_accept)
        begin
            new_txcoeff_legal <= triple_legal;
            if (triple_legal)
            begin
                new_txcoeff <= txcoeff_sync; // otherwise the last legal triple stays
            end
        end
    end

endmodule

// ==== src/rxeq_ctrl_pkg.sv ====
package rxeq_ctrl_pkg;

    typedef enum logic [1:0] {
        SCAN_IDLE   = 2'd0,
        SCAN_PRESET = 2'd1,
        SCAN_COEFF  = 2'd2
    } scan_state_t;

    typedef logic [2:0] iter_cnt_t; // wraps after eight coefficient requests

endpackage

// ==== src/rxeq_input_sync.sv ====
`timescale 1ns/1ps

module rxeq_input_sync
    import rxeq_types_pkg::*;
(
    input  logic     rxeq_scan_clk,
    input  logic     rxeq_scan_rst_n,
    input  logic     preset_valid,
    input  logic     new_txcoeff_req,
    input  txcoeff_t txcoeff,
    input  fslf_t    fs,
    input  fslf_t    lf,
    output logic     preset_valid_sync,
    output logic     new_txcoeff_req_sync,
    output txcoeff_t txcoeff_sync,
    output fslf_t    fs_sync,
    output fslf_t    lf_sync
);

    logic     preset_valid_q1;
    logic     new_txcoeff_req_q1;
    txcoeff_t txcoeff_q1;
    fslf_t    fs_q1;
    fslf_t    lf_q1;

    // data is held stable by the requester under the request, so it rides
    // through the same two stages as the request levels
    always_ff @(posedge rxeq_scan_clk)
    begin
        if (!rxeq_scan_rst_n)
        begin
            preset_valid_q1      <= 1'b0;
            new_txcoeff_req_q1   <= 1'b0;
            txcoeff_q1           <= '0;
            fs_q1                <= '0;
            lf_q1                <= '0;
            preset_valid_sync    <= 1'b0;
            new_txcoeff_req_sync <= 1'b0;
            txcoeff_sync         <= '0;
            fs_sync              <= '0;
            lf_sync              <= '0;
        end
        else
        begin
            preset_valid_q1      <= preset_valid;
            new_txcoeff_req_q1   <= new_txcoeff_req;
            txcoeff_q1           <= txcoeff;
            fs_q1                <= fs;
            lf_q1                <= lf;
            preset_valid_sync    <= preset_valid_q1;
            new_txcoeff_req_sync <= new_txcoeff_req_q1;
            txcoeff_sync         <= txcoeff_q1;
            fs_sync              <= fs_q1;
            lf_sync              <= lf_q1;
        end
    end

endmodule

// ==== src/rxeq_iter_counter.sv ====
`timescale 1ns/1ps

module rxeq_iter_counter
    import rxeq_ctrl_pkg::*;
#(
    parameter int LFFS_ITER  = 2,
    parameter int ADAPT_ITER = 2
)
(
    input  logic rxeq_scan_clk,
    input  logic rxeq_scan_rst_n,
    input  logic coeff_accept,
    input  logic coeff_busy,
    output logic lffs_sel,
    output logic adapt_done
);

    localparam iter_cnt_t LFFS_HIT  = iter_cnt_t'(LFFS_ITER - 1);
    localparam iter_cnt_t ADAPT_HIT = iter_cnt_t'(ADAPT_ITER - 1);

    iter_cnt_t iter_cnt;

    always_ff @(posedge rxeq_scan_clk)
    begin
        if (!rxeq_scan_rst_n)
        begin
            iter_cnt   <= '0;
            lffs_sel   <= 1'b0;
            adapt_done <= 1'b0;
        end
        else if (coeff_accept)
        begin
            iter_cnt   <= iter_cnt + 1'b1; // wraps modulo 8
            lffs_sel   <= (iter_cnt == LFFS_HIT);
            adapt_done <= (iter_cnt == ADAPT_HIT);
        end
        else if (!coeff_busy)
        begin
            lffs_sel   <= 1'b0; // flags only live for the duration of one request
            adapt_done <= 1'b0;
        end
    end

endmodule

// ==== src/rxeq_scan_ctrl.sv ====
`timescale 1ns/1ps

module rxeq_scan_ctrl
    import rxeq_ctrl_pkg::*;
(
    input  logic rxeq_scan_clk,
    input  logic rxeq_scan_rst_n,
    input  logic preset_valid_sync,
    input  logic new_txcoeff_req_sync,
    output logic preset_done,
    output logic new_txcoeff_done,
    output logic coeff_accept,
    output logic coeff_busy
);

    scan_state_t state_q;
    scan_state_t state_d;

    // preset has priority when both requests show up together in idle
    assign coeff_accept = (state_q == SCAN_IDLE) && !preset_valid_sync && new_txcoeff_req_sync;
    assign coeff_busy   = (state_q == SCAN_COEFF);

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            SCAN_IDLE:
            begin
                if (preset_valid_sync)
                begin
                    state_d = SCAN_PRESET;
                end
                else if (new_txcoeff_req_sync)
                begin
                    state_d = SCAN_COEFF;
                end
            end
            SCAN_PRESET:
            begin
                if (!preset_valid_sync)
                begin
                    state_d = SCAN_IDLE;
                end
            end
            SCAN_COEFF:
            begin
                if (!new_txcoeff_req_sync)
                begin
                    state_d = SCAN_IDLE;
                end
            end
            default:
            begin
                state_d = SCAN_IDLE; // recover from a corrupted encoding
            end
        endcase
    end

    // the done levels are registered off the next state so they rise with it
    always_ff @(posedge rxeq_scan_clk)
    begin
        if (!rxeq_scan_rst_n)
        begin
            state_q          <= SCAN_IDLE;
            preset_done      <= 1'b0;
            new_txcoeff_done <= 1'b0;
        end
        else
        begin
            state_q          <= state_d;
            preset_done      <= (state_d == SCAN_PRESET);
            new_txcoeff_done <= (state_d == SCAN_COEFF);
        end
    end

endmodule

// ==== src/rxeq_scan_top.sv ====
`timescale 1ns/1ps

module rxeq_scan_top
    import rxeq_types_pkg::*;
#(
    parameter int LFFS_ITER  = 2,
    parameter int ADAPT_ITER = 2
)
(
    input  logic     rxeq_scan_clk,
    input  logic     rxeq_scan_rst_n,
    input  logic     preset_valid,
    input  logic     new_txcoeff_req,
    input  txcoeff_t txcoeff,
    input  fslf_t    fs,
    input  fslf_t    lf,
    output logic     preset_done,
    output txcoeff_t new_txcoeff,
    output logic     new_txcoeff_done,
    output logic     new_txcoeff_legal,
    output logic     lffs_sel,
    output logic     adapt_done
);

    logic     preset_valid_sync;
    logic     new_txcoeff_req_sync;
    txcoeff_t txcoeff_sync;
    fslf_t    fs_sync;
    fslf_t    lf_sync;
    logic     coeff_accept;
    logic     coeff_busy;

    rxeq_input_sync i_input_sync (
        .rxeq_scan_clk        (rxeq_scan_clk),
        .rxeq_scan_rst_n      (rxeq_scan_rst_n),
        .preset_valid         (preset_valid),
        .new_txcoeff_req      (new_txcoeff_req),
        .txcoeff              (txcoeff),
        .fs                   (fs),
        .lf                   (lf),
        .preset_valid_sync    (preset_valid_sync),
        .new_txcoeff_req_sync (new_txcoeff_req_sync),
        .txcoeff_sync         (txcoeff_sync),
        .fs_sync              (fs_sync),
        .lf_sync              (lf_sync)
    );

    rxeq_scan_ctrl i_scan_ctrl (
        .rxeq_scan_clk        (rxeq_scan_clk),
        .rxeq_scan_rst_n      (rxeq_scan_rst_n),
        .preset_valid_sync    (preset_valid_sync),
        .new_txcoeff_req_sync (new_txcoeff_req_sync),
        .preset_done          (preset_done),
        .new_txcoeff_done     (new_txcoeff_done),
        .coeff_accept         (coeff_accept),
        .coeff_busy           (coeff_busy)
    );

    // datapath registers on the accept strobe, the same edge done rises on
    rxeq_coeff_eval i_coeff_eval (
        .rxeq_scan_clk     (rxeq_scan_clk),
        .rxeq_scan_rst_n   (rxeq_scan_rst_n),
        .coeff_accept      (coeff_accept),
        .txcoeff_sync      (txcoeff_sync),
        .fs_sync           (fs_sync),
        .lf_sync           (lf_sync),
        .new_txcoeff       (new_txcoeff),
        .new_txcoeff_legal (new_txcoeff_legal)
    );

    rxeq_iter_counter #(
        .LFFS_ITER  (LFFS_ITER),
        .ADAPT_ITER (ADAPT_ITER)
    ) i_iter_counter (
        .rxeq_scan_clk   (rxeq_scan_clk),
        .rxeq_scan_rst_n (rxeq_scan_rst_n),
        .coeff_accept    (coeff_accept),
        .coeff_busy      (coeff_busy),
        .lffs_sel        (lffs_sel),
        .adapt_done      (adapt_done)
    );

endmodule

// ==== src/rxeq_types_pkg.sv ====
package rxeq_types_pkg;

    // coefficient triple as carried on the PIPE side of the lane
    // [5:0] pre-cursor magnitude
    // [11:6] main cursor
    // [17:12] post-cursor magnitude
    typedef logic [17:0] txcoeff_t;

    typedef logic [5:0] coeff_field_t; // one cursor field of a triple

    // full swing and low frequency values share this width
    typedef logic [5:0] fslf_t;

    localparam int unsigned PRE_LSB  = 0;
    localparam int unsigned MAIN_LSB = 6;
    localparam int unsigned POST_LSB = 12;

endpackage
